// ==== verilog.f ====
+incdir+common
+incdir+bench
common/radioPkg.sv
rtl/registerBus.sv
tone/toneGenerator.sv
rxPath/decimator.sv
rxPath/portFifo.sv
rtl/radioContainer.sv
bench/radioContainerTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary -j 0 -Wno-fatal -f verilog.f --top-module radioContainerTb -o radioSim
	./obj_dir/radioSim | tee /dev/stderr | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== bench/radioModel.svh ====
`ifndef RADIO_MODEL_SVH
`define RADIO_MODEL_SVH

// Tone model: quadrant fold, then 12 shift-and-add rotations of the fixed vector
function automatic iqSample_t cordicTone(input logic [`PHASE_WIDTH-1:0] phase);
	logic signed [`SAMPLE_WIDTH-1:0] x;
	logic signed [`SAMPLE_WIDTH-1:0] y;
	logic signed [`SAMPLE_WIDTH-1:0] xShift;
	logic signed [`SAMPLE_WIDTH-1:0] yShift;
	logic signed [`ANGLE_WIDTH-1:0] angle;
	iqSample_t result;
	angle = phase[`PHASE_WIDTH-1 -: `ANGLE_WIDTH];		// 4096 is a full turn
	x = `TONE_AMPLITUDE;
	y = `TONE_AMPLITUDE;
	if (phase[`PHASE_WIDTH-1 -: 2] == 2'b01)
	begin
		x = -x;		// Rotated by +pi/2
		angle = angle - 1024;
	end
	else if (phase[`PHASE_WIDTH-1 -: 2] == 2'b10)
	begin
		y = -y;		// Rotated by -pi/2
		angle = angle + 1024;
	end
	for (int n = 0; n < `CORDIC_STAGES; n++)
	begin
		xShift = x >>> n;
		yShift = y >>> n;
		if (angle < 0)
		begin
			x = x + yShift;
			y = y - xShift;
			angle = angle + cordicAtanTable[n];
		end
		else
		begin
			x = x - yShift;
			y = y + xShift;
			angle = angle - cordicAtanTable[n];
		end
	end
	result.i = x;
	result.q = y;
	return result;
endfunction

// Fibonacci LFSR, taps 32 22 2 1, new bit enters at bit 0
function automatic logic [31:0] lfsrShift(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

`endif

// ==== bench/radioContainerTb.sv ====
`timescale 1ns/1ps
`include "radio_settings.svh"

module radioContainerTb import radioPkg::*;
();
	`include "radioModel.svh"

	typedef struct packed {
		logic [31:0] step;
		logic [4:0] rate;
		logic [7:0] count;		// Tone samples and rx sums
		logic withheld;		// Host holds back credits
	} testRow_t;

	localparam int ROWS = 5;
	localparam testRow_t TEST_ROWS [0:ROWS-1] = '{
		'{32'h01234567, 5'd1, 8'd8, 1'b0},
		'{32'h10000000, 5'd4, 8'd6, 1'b0},
		'{32'hFEDCBA98, 5'd0, 8'd5, 1'b0},		// Rate 0 acts as 1
		'{32'h08000000, 5'd16, 8'd4, 1'b0},
		'{32'h3456789A, 5'd2, 8'd24, 1'b1}		// Enough sums to overflow
	};

	logic clock = 1'b0;
	logic reset;
	regBus_t regBus;
	logic [7:0] readData;
	logic readValid;
	logic [5:0] rfSelect;
	logic [3:0] ledSelect;
	logic txStrobe;
	iqSample_t txIq;
	logic txValid;
	logic rxStrobe;
	iqSample_t rxIq;
	portWord_t portData;
	logic portValid;
	logic portCredit = 1'b0;

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int portWordsSeen = 0;
	int creditsGranted = 0;		// Extra credits from the main process
	int creditsIssued = 0;
	int creditsOwed = 0;
	logic creditsFree = 1'b1;
	logic [31:0] lfsrState = 32'd70347;
	iqSample_t expTone [$];
	portWord_t expPort [$];
	int strobeCycles [$];

	radioContainer radioContainer_inst (
		.clock(clock),
		.reset(reset),
		.regBus(regBus),
		.readData(readData),
		.readValid(readValid),
		.rfSelect(rfSelect),
		.ledSelect(ledSelect),
		.txStrobe(txStrobe),
		.txIq(txIq),
		.txValid(txValid),
		.rxStrobe(rxStrobe),
		.rxIq(rxIq),
		.portData(portData),
		.portValid(portValid),
		.portCredit(portCredit)
	);

	initial
	begin
		forever #5 clock = ~clock;
	end

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("ERR %0t %s: got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	function automatic int watchdogCycles();
		int total;
		total = 0;
		for (int r = 0; r < ROWS; r++)
			total += TEST_ROWS[r].count * ((TEST_ROWS[r].rate == 0) ? 1 : TEST_ROWS[r].rate);
		return total * 40 + 2000;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [11:0] drawSampleBits();
		logic [11:0] value;
		value = '0;
		for (int b = 0; b < 12; b++)
		begin
			lfsrState = lfsrShift(lfsrState);
			value = {value[10:0], lfsrState[0]};
		end
		return value;
	endfunction

	task automatic writeReg(input logic [7:0] address, input logic [7:0] value);
		@(posedge clock);
		regBus <= '{address: address, write: 1'b1, read: 1'b0, writeData: value};
		@(posedge clock);
		regBus <= '0;		// Write sampled on this edge
	endtask

	task automatic readReg(input logic [7:0] address, output logic [7:0] value);
		@(posedge clock);
		regBus <= '{address: address, write: 1'b0, read: 1'b1, writeData: 8'h00};
		@(posedge clock);
		regBus <= '0;
		checkValue(readValid, 1'b0, "readValid early");
		@(posedge clock);
		checkValue(readValid, 1'b1, "readValid one cycle after strobe");
		value = readData;
	endtask

	task automatic expectReg(input logic [7:0] address, input logic [7:0] expected);
		logic [7:0] value;
		readReg(address, value);
		checkValue(value, expected, $sformatf("register %h", address));
	endtask

	task automatic registerTest();
		checkValue(ledSelect, 4'b0100, "ledSelect after reset");		// Only empty set
		expectReg(`REG_ID_LO, 8'(`IDENTIFIER));
		expectReg(`REG_ID_HI, 8'(`IDENTIFIER >> 8));
		expectReg(`REG_VERSION_LO, 8'(`VERSION));
		expectReg(`REG_VERSION_HI, 8'(`VERSION >> 8));
		writeReg(`REG_RF_SELECT, 8'h2A);
		@(posedge clock);
		checkValue(rfSelect, 6'h2A, "rfSelect port");
		expectReg(`REG_RF_SELECT, 8'h2A);
		writeReg(`REG_TONE_STEP2, 8'h5C);
		expectReg(`REG_TONE_STEP2, 8'h5C);
		writeReg(`REG_RX_RATE, 8'h07);
		expectReg(`REG_RX_RATE, 8'h07);
		expectReg(8'h7F, 8'h00);		// Unmapped
		expectReg(`REG_RX_STATUS, 8'h04);		// Empty after reset
		$display("Test registers done, errors %0d", errorCount);
	endtask

	task automatic runRow(input int index);
		testRow_t row;
		logic [31:0] phase;
		int rate;
		int groupI;
		int groupQ;
		int inGroup;
		int pushed;
		int startSeen;
		iqSample_t sample;
		row = TEST_ROWS[index];
		rate = (row.rate == 0) ? 1 : row.rate;

		// Tone, clear then enable so phase restarts at 0
		writeReg(`REG_TONE_CTRL, 8'h02);
		for (int b = 0; b < 4; b++)
			writeReg(8'(`REG_TONE_STEP0 + b), row.step[8*b +: 8]);
		writeReg(`REG_TONE_CTRL, 8'h01);
		phase = '0;
		for (int k = 0; k < row.count; k++)
		begin
			expTone.push_back(cordicTone(phase));
			phase = phase + row.step;
			@(posedge clock);
			txStrobe <= 1'b1;
		end
		@(posedge clock);
		txStrobe <= 1'b0;
		checkValue(ledSelect, 4'b0101, "ledSelect tone enabled");		// Port still empty
		while (expTone.size() > 0)
			@(posedge clock);
		writeReg(`REG_TONE_CTRL, 8'h00);

		// Receive, samples while disabled must give no word
		creditsFree <= !row.withheld;
		writeReg(`REG_RX_CTRL, 8'h02);
		writeReg(`REG_RX_RATE, 8'(row.rate));
		writeReg(`REG_RX_CTRL, 8'h00);
		for (int k = 0; k < 3; k++)
		begin
			sample.q = drawSampleBits();
			sample.i = drawSampleBits();
			@(posedge clock);
			rxStrobe <= 1'b1;
			rxIq <= sample;
		end
		@(posedge clock);
		rxStrobe <= 1'b0;
		repeat (4) @(posedge clock);
		writeReg(`REG_RX_CTRL, 8'h01);

		startSeen = portWordsSeen;
		groupI = 0;
		groupQ = 0;
		inGroup = 0;
		pushed = 0;
		for (int n = 0; n < rate * row.count; n++)
		begin
			sample.q = drawSampleBits();
			sample.i = drawSampleBits();
			@(posedge clock);
			rxStrobe <= 1'b1;
			rxIq <= sample;
			groupI += sample.i;
			groupQ += sample.q;
			inGroup++;
			if (inGroup == rate)
			begin
				// Words past credits plus depth are dropped
				if (!row.withheld || pushed < `PORT_CREDITS + `PORT_DEPTH)
					expPort.push_back('{q: 16'(groupQ), i: 16'(groupI)});
				pushed++;
				groupI = 0;
				groupQ = 0;
				inGroup = 0;
			end
		end
		@(posedge clock);
		rxStrobe <= 1'b0;

		if (row.withheld)
		begin
			repeat (4) @(posedge clock);		// Last sum through FIFO
			checkValue(portWordsSeen - startSeen, `PORT_CREDITS, "words sent without credit");
			checkValue(ledSelect, 4'b1010, "ledSelect port full");		// Full, rx on
			expectReg(`REG_RX_STATUS, 8'h03);		// Overflow and full
			creditsFree <= 1'b1;
			creditsGranted <= creditsGranted + `PORT_CREDITS;
		end
		while (expPort.size() > 0)
			@(posedge clock);
		if (row.withheld)
		begin
			expectReg(`REG_RX_STATUS, 8'h05);		// Drained, overflow still held
			writeReg(`REG_RX_CTRL, 8'h02);
			expectReg(`REG_RX_STATUS, 8'h04);		// Empty, overflow released
		end
		writeReg(`REG_RX_CTRL, 8'h00);
		$display("Test row %0d step %h rate %0d done, errors %0d",
			index, row.step, row.rate, errorCount);
	endtask

	// Monitors sample pre-edge values, host credits driven here
	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (!reset && txStrobe)
			strobeCycles.push_back(cycleCount);
		if (txValid)
		begin
			if (expTone.size() == 0)
			begin
				errorCount++;
				$display("Unexpected tone sample at %0t", $time);
			end
			else
			begin
				checkValue(cycleCount - strobeCycles.pop_front(), 14, "txValid latency");
				checkValue(txIq, expTone.pop_front(), "txIq");
			end
		end
		if (portValid)
		begin
			portWordsSeen <= portWordsSeen + 1;
			if (expPort.size() == 0)
			begin
				errorCount++;
				$display("Unexpected port word at %0t", $time);
			end
			else
				checkValue(portData, expPort.pop_front(), "portData");
		end
		if (portValid && creditsFree)
			creditsOwed <= creditsOwed + 1;
		if (creditsGranted + creditsOwed > creditsIssued)
		begin
			portCredit <= 1'b1;		// One credit back per cycle
			creditsIssued <= creditsIssued + 1;
		end
		else
			portCredit <= 1'b0;
	end

	initial
	begin
		int limit;
		limit = watchdogCycles();
		repeat (limit) @(posedge clock);
		$display("Run timed out after %0d cycles", limit);
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		regBus = '0;
		txStrobe = 1'b0;
		rxStrobe = 1'b0;
		rxIq = '0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		registerTest();
		for (int r = 0; r < ROWS; r++)
			runRow(r);
		repeat (4) @(posedge clock);
		$display("Tests %0d, checks %0d, errors %0d", ROWS + 1, checkCount, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== rtl/radioContainer.sv ====
`timescale 1ns/1ps

module radioContainer import radioPkg::*;
(
	input logic clock,
	input logic reset,
	// Host register bus
	input regBus_t regBus,
	output logic [7:0] readData,
	output logic readValid,
	output logic [5:0] rfSelect,		// RF switch lines
	output logic [3:0] ledSelect,		// {portFull, portEmpty, rx enable, tone enable}
	// Transmit tone
	input logic txStrobe,
	output iqSample_t txIq,
	output logic txValid,
	// Receive samples in
	input logic rxStrobe,
	input iqSample_t rxIq,
	// Host port, credit flow
	output portWord_t portData,
	output logic portValid,
	input logic portCredit
);
	toneControl_t toneControl;
	rxControl_t rxControl;
	portWord_t sumWord;
	logic sumValid;
	logic [2:0] fifoStatus;		// {empty, full, overflow}

	assign ledSelect = {fifoStatus[1], fifoStatus[2], rxControl.enable, toneControl.enable};

	registerBus registerBus_inst (
		.clock(clock),
		.reset(reset),
		.regBus(regBus),
		.readData(readData),
		.readValid(readValid),
		.toneControl(toneControl),
		.rxControl(rxControl),
		.rfSelect(rfSelect),
		.fifoStatus(fifoStatus)
	);

	toneGenerator toneGenerator_inst (
		.clock(clock),
		.reset(reset),
		.toneControl(toneControl),
		.txStrobe(txStrobe),
		.txIq(txIq),
		.txValid(txValid)
	);

	decimator decimator_inst (
		.clock(clock),
		.reset(reset),
		.rxControl(rxControl),
		.rxStrobe(rxStrobe),
		.rxIq(rxIq),
		.sumWord(sumWord),
		.sumValid(sumValid)
	);

	portFifo portFifo_inst (
		.clock(clock),
		.reset(reset),
		.rxControl(rxControl),
		.sumWord(sumWord),
		.sumValid(sumValid),
		.portData(portData),
		.portValid(portValid),
		.portCredit(portCredit),
		.fifoStatus(fifoStatus)
	);

endmodule

// ==== rxPath/portFifo.sv ====
`timescale 1ns/1ps
`include "radio_settings.svh"

module portFifo import radioPkg::*;
(
	input logic clock,
	input logic reset,
	input rxControl_t rxControl,
	input portWord_t sumWord,
	input logic sumValid,
	output portWord_t portData,
	output logic portValid,		// One pulse per word sent
	input logic portCredit,		// Host frees one word slot
	output logic [2:0] fifoStatus		// {empty, full, overflow}
);
	localparam int DEPTH = `PORT_DEPTH;
	localparam int PTRW = $clog2(DEPTH);
	localparam int CW = `CREDIT_WIDTH;

	portWord_t storage [0:DEPTH-1];
	logic [PTRW:0] writePtr;		// Extra bit tells full from empty
	logic [PTRW:0] readPtr;
	logic [CW-1:0] credits;
	logic full;
	logic empty;
	logic overflow;
	logic pushWord;
	logic sendWord;

	assign empty = writePtr == readPtr;
	assign full = (writePtr[PTRW-1:0] == readPtr[PTRW-1:0]) && (writePtr[PTRW] != readPtr[PTRW]);
	assign pushWord = sumValid && !full && !rxControl.clear;
	assign sendWord = !empty && (credits != '0) && !rxControl.clear;	// Needs a credit
	assign fifoStatus = {empty, full, overflow};

	always_ff @(posedge clock)
	begin
		if (pushWord)
			storage[writePtr[PTRW-1:0]] <= sumWord;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			writePtr <= '0;
			readPtr <= '0;
			overflow <= 1'b0;
			portValid <= 1'b0;
			credits <= CW'(`PORT_CREDITS);
		end
		else
		begin
			portValid <= sendWord;
			// Credits survive rx clear
			credits <= credits + CW'(portCredit) - CW'(sendWord);
			if (rxControl.clear)
			begin
				writePtr <= '0;
				readPtr <= '0;
				overflow <= 1'b0;		// Sticky until cleared
			end
			else
			begin
				if (pushWord)
					writePtr <= writePtr + 1'b1;
				if (sendWord)
					readPtr <= readPtr + 1'b1;
				if (sumValid && full)
					overflow <= 1'b1;		// Word dropped
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (sendWord)
			portData <= storage[readPtr[PTRW-1:0]];
	end

endmodule

// ==== rxPath/decimator.sv ====
`timescale 1ns/1ps
`include "radio_settings.svh"

module decimator import radioPkg::*;
(
	input logic clock,
	input logic reset,
	input rxControl_t rxControl,
	input logic rxStrobe,
	input iqSample_t rxIq,
	output portWord_t sumWord,
	output logic sumValid		// One pulse per completed sum
);
	localparam int SUMW = `SUM_WIDTH;
	localparam int SW = `SAMPLE_WIDTH;

	logic signed [SUMW-1:0] sumI;
	logic signed [SUMW-1:0] sumQ;
	logic signed [SUMW-1:0] nextI;
	logic signed [SUMW-1:0] nextQ;
	logic [`RATE_WIDTH-1:0] sampleCount;		// Samples already in the sum
	logic [`RATE_WIDTH-1:0] effectiveRate;
	logic takeSample;
	logic lastSample;

	assign effectiveRate = (rxControl.rate == '0) ? `RATE_WIDTH'(1) : rxControl.rate;
	assign takeSample = rxStrobe && rxControl.enable;
	assign lastSample = sampleCount == effectiveRate - 1'b1;

	// Sign extend, 16 samples of 12 bits fit in 16
	assign nextI = sumI + {{(SUMW - SW){rxIq.i[SW-1]}}, rxIq.i};
	assign nextQ = sumQ + {{(SUMW - SW){rxIq.q[SW-1]}}, rxIq.q};

	always_ff @(posedge clock)
	begin
		if (reset || rxControl.clear)
		begin
			sumI <= '0;
			sumQ <= '0;
			sampleCount <= '0;
			sumValid <= 1'b0;
		end
		else
		begin
			sumValid <= takeSample && lastSample;
			if (takeSample && lastSample)
			begin
				sumI <= '0;		// Dump and start next group
				sumQ <= '0;
				sampleCount <= '0;
			end
			else if (takeSample)
			begin
				sumI <= nextI;
				sumQ <= nextQ;
				sampleCount <= sampleCount + 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (takeSample && lastSample)
		begin
			sumWord.i <= nextI;		// Includes the rate-th sample
			sumWord.q <= nextQ;
		end
	end

endmodule

// ==== tone/toneGenerator.sv ====
`timescale 1ns/1ps
`include "radio_settings.svh"

module toneGenerator import radioPkg::*;
(
	input logic clock,
	input logic reset,
	input toneControl_t toneControl,
	input logic txStrobe,		// One pulse per output sample
	output iqSample_t txIq,
	output logic txValid		// CORDIC_STAGES+2 cycles after its strobe
);
	localparam int STAGES = `CORDIC_STAGES;
	localparam int PW = `PHASE_WIDTH;
	localparam int AW = `ANGLE_WIDTH;
	localparam int SW = `SAMPLE_WIDTH;
	localparam logic signed [SW-1:0] AMPLITUDE = SW'(`TONE_AMPLITUDE);
	localparam logic signed [AW-1:0] QUARTER_TURN = AW'(1 << (AW - 2));	// pi/2

	logic [PW-1:0] phase;
	logic takeSample;
	logic [1:0] quadrant;
	logic signed [AW-1:0] angle;

	// Stage 0 holds the folded vector, stage n the result of iteration n-1
	logic signed [SW-1:0] xPipe [0:STAGES];
	logic signed [SW-1:0] yPipe [0:STAGES];
	logic signed [AW-1:0] aPipe [0:STAGES-1];	// Last residual angle is not needed
	logic [STAGES:0] validPipe;

	assign takeSample = txStrobe && toneControl.enable && !toneControl.clear;
	assign quadrant = phase[PW-1 -: 2];
	assign angle = phase[PW-1 -: AW];		// Top bits, full turn is 4096

	// Phase accumulator, sample uses current phase then steps
	always_ff @(posedge clock)
	begin
		if (reset || toneControl.clear)
			phase <= '0;
		else if (takeSample)
			phase <= phase + toneControl.step;
	end

	always_ff @(posedge clock)
	begin
		// Quadrant fold keeps the CORDIC angle within +-pi/2
		case (quadrant)
			2'b01:		// pi/2 to pi, pre-rotate by +pi/2
			begin
				xPipe[0] <= -AMPLITUDE;
				yPipe[0] <= AMPLITUDE;
				aPipe[0] <= angle - QUARTER_TURN;
			end
			2'b10:		// -pi to -pi/2, pre-rotate by -pi/2
			begin
				xPipe[0] <= AMPLITUDE;
				yPipe[0] <= -AMPLITUDE;
				aPipe[0] <= angle + QUARTER_TURN;
			end
			default:	// Already within +-pi/2
			begin
				xPipe[0] <= AMPLITUDE;
				yPipe[0] <= AMPLITUDE;
				aPipe[0] <= angle;
			end
		endcase

		// Shift-and-add iterations, direction set by sign of residual angle
		for (int stage = 0; stage < STAGES; stage++)
		begin
			if (aPipe[stage][AW-1])
			begin
				xPipe[stage+1] <= xPipe[stage] + (yPipe[stage] >>> stage);	// Clockwise
				yPipe[stage+1] <= yPipe[stage] - (xPipe[stage] >>> stage);
			end
			else
			begin
				xPipe[stage+1] <= xPipe[stage] - (yPipe[stage] >>> stage);
				yPipe[stage+1] <= yPipe[stage] + (xPipe[stage] >>> stage);
			end
		end

		for (int stage = 0; stage < STAGES - 1; stage++)
		begin
			if (aPipe[stage][AW-1])
				aPipe[stage+1] <= aPipe[stage] + cordicAtanTable[stage];
			else
				aPipe[stage+1] <= aPipe[stage] - cordicAtanTable[stage];
		end
	end

	// Valid travels alongside the data, clear flushes everything in flight
	always_ff @(posedge clock)
	begin
		if (reset || toneControl.clear)
		begin
			validPipe <= '0;
			txValid <= 1'b0;
		end
		else
		begin
			validPipe <= {validPipe[STAGES-1:0], takeSample};
			txValid <= validPipe[STAGES];
		end
	end

	// Output register, I is the cosine leg
	always_ff @(posedge clock)
	begin
		txIq.i <= xPipe[STAGES];
		txIq.q <= yPipe[STAGES];
	end

endmodule

// ==== rtl/registerBus.sv ====
`timescale 1ns/1ps
`include "radio_settings.svh"

module registerBus import radioPkg::*;
(
	input logic clock,
	input logic reset,
	input regBus_t regBus,
	output logic [7:0] readData,
	output logic readValid,
	output toneControl_t toneControl,
	output rxControl_t rxControl,
	output logic [5:0] rfSelect,
	input logic [2:0] fifoStatus		// {empty, full, overflow}
);
	localparam logic [15:0] ID_WORD = `IDENTIFIER;
	localparam logic [15:0] VERSION_WORD = `VERSION;

	logic [7:0] toneCtrlReg;		// Whole byte kept so it reads back as written
	logic [7:0] rxCtrlReg;
	logic [3:0][7:0] toneStep;		// Byte 0 is the low byte
	logic [`RATE_WIDTH-1:0] rxRate;
	logic [7:0] readMux;

	// Writes land on the edge that samples the strobe
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rfSelect <= '0;
			toneCtrlReg <= '0;
			rxCtrlReg <= '0;
			toneStep <= '0;
			rxRate <= '0;
		end
		else if (regBus.write)
		begin
			case (regBus.address)
				`REG_RF_SELECT: rfSelect <= regBus.writeData[5:0];
				`REG_TONE_CTRL: toneCtrlReg <= regBus.writeData;
				`REG_TONE_STEP0: toneStep[0] <= regBus.writeData;
				`REG_TONE_STEP1: toneStep[1] <= regBus.writeData;
				`REG_TONE_STEP2: toneStep[2] <= regBus.writeData;
				`REG_TONE_STEP3: toneStep[3] <= regBus.writeData;
				`REG_RX_CTRL: rxCtrlReg <= regBus.writeData;
				`REG_RX_RATE: rxRate <= regBus.writeData[`RATE_WIDTH-1:0];
				default: ;		// Read-only or unmapped
			endcase
		end
	end

	always_comb
	begin
		case (regBus.address)
			`REG_ID_LO: readMux = ID_WORD[7:0];
			`REG_ID_HI: readMux = ID_WORD[15:8];
			`REG_VERSION_LO: readMux = VERSION_WORD[7:0];
			`REG_VERSION_HI: readMux = VERSION_WORD[15:8];
			`REG_RF_SELECT: readMux = {2'b00, rfSelect};
			`REG_TONE_CTRL: readMux = toneCtrlReg;
			`REG_TONE_STEP0: readMux = toneStep[0];
			`REG_TONE_STEP1: readMux = toneStep[1];
			`REG_TONE_STEP2: readMux = toneStep[2];
			`REG_TONE_STEP3: readMux = toneStep[3];
			`REG_RX_CTRL: readMux = rxCtrlReg;
			`REG_RX_RATE: readMux = {{(8 - `RATE_WIDTH){1'b0}}, rxRate};
			`REG_RX_STATUS: readMux = {5'b00000, fifoStatus};
			default: readMux = 8'h00;		// Unmapped reads zero
		endcase
	end

	// Read data comes back one cycle after the strobe
	always_ff @(posedge clock)
	begin
		if (reset)
			readValid <= 1'b0;
		else
			readValid <= regBus.read;
	end

	always_ff @(posedge clock)
	begin
		if (regBus.read)
			readData <= readMux;
	end

	assign toneControl = '{enable: toneCtrlReg[0], clear: toneCtrlReg[1], step: toneStep};
	assign rxControl = '{enable: rxCtrlReg[0], clear: rxCtrlReg[1], rate: rxRate};

endmodule

// ==== common/radioPkg.sv ====
`include "radio_settings.svh"

package radioPkg;

	// Host register bus, one access per strobe
	typedef struct packed {
		logic [7:0] address;
		logic write;		// Write strobe
		logic read;			// Read strobe
		logic [7:0] writeData;
	} regBus_t;

	// Complex baseband sample, Q in the upper half
	typedef struct packed {
		logic signed [`SAMPLE_WIDTH-1:0] q;
		logic signed [`SAMPLE_WIDTH-1:0] i;
	} iqSample_t;

	// Decimated sum word sent to the host port
	typedef struct packed {
		logic signed [`SUM_WIDTH-1:0] q;
		logic signed [`SUM_WIDTH-1:0] i;
	} portWord_t;

	typedef struct packed {
		logic enable;
		logic clear;						// Empties pipeline and zeroes phase
		logic [`PHASE_WIDTH-1:0] step;	// Phase increment per sample
	} toneControl_t;

	typedef struct packed {
		logic enable;
		logic clear;					// Drops partial sum and FIFO contents
		logic [`RATE_WIDTH-1:0] rate;	// 1 to 16
	} rxControl_t;

	// atan(2^-i) with 1024 standing for pi/2
	localparam logic signed [`ANGLE_WIDTH-1:0] cordicAtanTable [0:`CORDIC_STAGES-1] = '{
		12'sd512,	// 45 degrees
		12'sd302,
		12'sd160,
		12'sd81,
		12'sd41,
		12'sd20,
		12'sd10,
		12'sd5,
		12'sd3,
		12'sd1,
		12'sd1,
		12'sd0		// Below one angle step
	};

endpackage

// ==== common/radio_settings.svh ====
`ifndef RADIO_SETTINGS_SVH
`define RADIO_SETTINGS_SVH

// Identity words returned by the read-only registers
`define IDENTIFIER 16'hA5D1
`define VERSION 16'h0103

// Standard registers
`define REG_ID_LO 8'h00
`define REG_ID_HI 8'h01
`define REG_VERSION_LO 8'h02
`define REG_VERSION_HI 8'h03
`define REG_RF_SELECT 8'h04		// 6 switch bits

// Transmit tone channel
`define REG_TONE_CTRL 8'h10		// bit0 enable, bit1 clear
`define REG_TONE_STEP0 8'h11		// Phase step, little-endian bytes
`define REG_TONE_STEP1 8'h12
`define REG_TONE_STEP2 8'h13
`define REG_TONE_STEP3 8'h14

// Receive channel
`define REG_RX_CTRL 8'h20		// bit0 enable, bit1 clear
`define REG_RX_RATE 8'h21		// Samples per sum, 0 acts as 1
`define REG_RX_STATUS 8'h22		// bit0 overflow, bit1 full, bit2 empty

// Datapath widths
`define SAMPLE_WIDTH 12
`define SUM_WIDTH 16
`define PHASE_WIDTH 32
`define ANGLE_WIDTH 12		// 1024 is pi/2
`define RATE_WIDTH 5
`define CREDIT_WIDTH 8

`define CORDIC_STAGES 12
`define TONE_AMPLITUDE 600		// Times CORDIC gain ~1.647 stays inside 12 bits
`define PORT_DEPTH 16
`define PORT_CREDITS 4

`endif
